/* filelist.f */
+incdir+rtl
rtl/xfer_pkg.sv
rtl/cdc_sync_bits.sv
rtl/async_fifo_core.sv
rtl/write_ingress.sv
rtl/read_egress.sv
rtl/xfer_top.sv
sim/tb_xfer.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --top-module tb_xfer -f filelist.f > build.log 2>&1 \
    || { cat build.log; echo "Build failed."; exit 1; }
./obj_dir/Vtb_xfer > sim.log 2>&1 \
    || { cat sim.log; echo "Simulation did not run to completion."; exit 1; }
cat sim.log
grep -q "SOME TESTS FAILED" sim.log \
    && { echo "Result: fail"; exit 1; } \
    || { echo "Result: pass"; exit 0; }

/* sim/xfer_stim.txt */
// Columns: idle wclk cycles before the strobe (hex), then the byte to strobe (hex).
// Sparse bytes, a back-to-back burst of 24 that overflows the FIFO, then sparse again.
0a 11
08 22
0c 33
09 44
10 55
08 66
0a 77
08 88
0c 80
00 81
00 82
00 83
00 84
00 85
00 86
00 87
00 88
00 89
00 8a
00 8b
00 8c
00 8d
00 8e
00 8f
00 90
00 91
00 92
00 93
00 94
00 95
00 96
00 97
0c a1
0a a2
0e a3

/* sim/tb_xfer.sv */
// Testbench for xfer_top that replays the stim file through the write side and checks the read side.
`timescale 1ns/1ps
`default_nettype none

module tb_xfer
    import xfer_pkg::*;
();

    localparam string STIM_FILE = "sim/xfer_stim.txt";
    localparam int    SEQ_MOD   = 16;
    localparam real   CLK_NS    = 20.0;
    localparam real   MARGIN_NS = 2000.0;

    logic        wclk;
    logic        rclk;
    logic        rreset_n;
    logic        in_valid;
    data_t       in_data;
    logic [7:0]  drop_count;
    logic        out_valid;
    data_t       out_data;
    logic        out_gap;
    logic        out_parity_err;

    int    stim_idle[$];
    data_t stim_byte[$];
    data_t ref_data[$];
    int    ref_tag[$];
    int    total_idle   = 0;
    int    sent         = 0;
    int    rx_count     = 0;
    int    model_drops  = 0;
    int    value_errors = 0;
    int    other_errors = 0;
    bit    stim_loaded  = 1'b0;
    bit    burst_seen   = 1'b0;
    bit    sparse_drop  = 1'b0;

    xfer_top dut_i (
        .wclk           (wclk),
        .rclk           (rclk),
        .rreset_n       (rreset_n),
        .in_valid       (in_valid),
        .in_data        (in_data),
        .drop_count     (drop_count),
        .out_valid      (out_valid),
        .out_data       (out_data),
        .out_gap        (out_gap),
        .out_parity_err (out_parity_err)
    );

    always #10 wclk = ~wclk;
    always #17 rclk = ~rclk;  // Unrelated, slower read clock.

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    task automatic report_mismatch(string name, int got, int exp);
        $display("error t=%0t %s got %0h expected %0h", $time, name, got, exp);
        value_errors++;
    endtask

    task automatic load_stim(output bit ok);
        int    fd;
        int    code;
        int    idle_v;
        int    byte_v;
        string line;
        ok = 1'b0;
        fd = $fopen(STIM_FILE, "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                code = $fgets(line, fd);
                if (code != 0 && line.len() > 1 && line[0] != "/") begin
                    if ($sscanf(line, "%h %h", idle_v, byte_v) == 2) begin
                        stim_idle.push_back(idle_v);
                        stim_byte.push_back(data_t'(byte_v));
                        total_idle += idle_v;
                    end
                end
            end
            $fclose(fd);
            ok = stim_byte.size() > 0;
        end
    endtask

    task automatic send_stream();
        int tag;
        tag = 0;
        for (int i = 0; i < stim_byte.size(); i++) begin
            repeat (stim_idle[i]) begin
                @(posedge wclk);
                in_valid <= 1'b0;
            end
            if (stim_idle[i] == 0) begin
                burst_seen = 1'b1;
            end
            @(posedge wclk);
            in_valid <= 1'b1;
            in_data  <= stim_byte[i];
            ref_data.push_back(stim_byte[i]);
            ref_tag.push_back(tag);
            tag = (tag + 1) % SEQ_MOD;  // Tag counts every strobe, dropped or not.
            sent++;
        end
        @(posedge wclk);
        in_valid <= 1'b0;
    endtask

    // No byte repeats while still pending, so a byte identifies its reference entry.
    task automatic check_output();
        int skipped;
        skipped = 0;
        rx_count++;
        while (ref_data.size() > 0 && ref_data[0] !== out_data) begin
            void'(ref_data.pop_front());
            void'(ref_tag.pop_front());
            skipped++;
        end
        if (ref_data.size() == 0) begin
            $display("%0t: received byte %0h matches no pending sent byte", $time, out_data);
            other_errors++;
        end else begin
            if (rx_count == 1 && ref_tag[0] != 0) begin
                $display("%0t: first received word is not the word with tag 0", $time);
                other_errors++;
            end
            void'(ref_data.pop_front());
            void'(ref_tag.pop_front());
        end
        model_drops += skipped;
        if (out_gap !== (skipped > 0)) begin
            report_mismatch("out_gap", int'(out_gap), int'(skipped > 0));
        end
        if (out_parity_err !== 1'b0) begin
            report_mismatch("out_parity_err", int'(out_parity_err), 0);
        end
    endtask

    // ------------------------------------------------------------------------
    // Monitors
    // ------------------------------------------------------------------------
    always @(negedge rclk) begin
        if (rreset_n && out_valid === 1'b1) begin
            check_output();
        end
    end

    always @(negedge wclk) begin
        if (!rreset_n && (out_valid !== 1'b0 || drop_count !== '0)) begin
            $display("%0t: outputs left their reset values while reset was asserted", $time);
            other_errors++;
        end
        if (rreset_n && !burst_seen && !sparse_drop && drop_count !== '0) begin
            $display("%0t: drop_count rose during sparse traffic", $time);
            other_errors++;
            sparse_drop = 1'b1;
        end
    end

    initial begin : watchdog
        real limit_ns;
        wait (stim_loaded);
        limit_ns = (total_idle + stim_byte.size()) * CLK_NS + MARGIN_NS;
        #(limit_ns);
        $display("timeout: the stream did not drain within %0.0f ns", limit_ns);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin : main
        bit ok;
        wclk     = 1'b0;
        rclk     = 1'b0;
        rreset_n = 1'b0;
        in_valid = 1'b0;
        in_data  = '0;
        load_stim(ok);
        if (!ok) begin
            $display("could not read any stimulus from %s", STIM_FILE);
            $display("SOME TESTS FAILED");
            $finish;
        end else begin
            stim_loaded = 1'b1;
            repeat (3) @(posedge wclk);
            rreset_n <= 1'b1;
            send_stream();
            while (ref_data.size() != 0) begin
                @(posedge rclk);
            end
            repeat (4) @(posedge wclk);
            if (rx_count + int'(drop_count) != sent) begin
                report_mismatch("received plus drop_count", rx_count + int'(drop_count), sent);
            end
            if (int'(drop_count) != model_drops) begin
                report_mismatch("drop_count", int'(drop_count), model_drops);
            end
            if (model_drops == 0) begin
                $display("the burst caused no overflow, so drop handling went untested");
                other_errors++;
            end
            $display("sent %0d received %0d dropped %0d, value errors %0d, other errors %0d",
                     sent, rx_count, model_drops, value_errors, other_errors);
            if (value_errors + other_errors == 0) begin
                $display("ALL TESTS PASSED");
            end else begin
                $display("SOME TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* rtl/xfer_top.sv */
// Top level of the byte transfer path, to be instantiated with the write and read clocks.
`timescale 1ns/1ps
`default_nettype none

`include "xfer_config.svh"

module xfer_top
    import xfer_pkg::*;
(
    input  logic                    wclk,
    input  logic                    rclk,
    input  logic                    rreset_n,
    input  logic                    in_valid,
    input  data_t                   in_data,
    output logic [`XFER_DROP_W-1:0] drop_count,
    output logic                    out_valid,
    output data_t                   out_data,
    output logic                    out_gap,
    output logic                    out_parity_err
);

    logic       wrst_n;
    logic       rrst_n;
    logic       push_valid;
    logic       push_ready;
    fifo_word_t push_word;
    logic       pop_valid;
    logic       pop_ready;
    fifo_word_t pop_word;

    // ------------------------------------------------------------------------
    // Reset release, asserted async and deasserted per domain
    // ------------------------------------------------------------------------
    cdc_sync_bits #(.WIDTH(1), .STAGES(`XFER_SYNC_STAGES)) wrst_sync_i (
        .clk    (wclk),
        .arst_n (rreset_n),
        .d      (1'b1),
        .q      (wrst_n)
    );

    cdc_sync_bits #(.WIDTH(1), .STAGES(`XFER_SYNC_STAGES)) rrst_sync_i (
        .clk    (rclk),
        .arst_n (rreset_n),
        .d      (1'b1),
        .q      (rrst_n)
    );

    // ------------------------------------------------------------------------
    // Pipeline
    // ------------------------------------------------------------------------
    write_ingress ingress_i (
        .wclk       (wclk),
        .wrst_n     (wrst_n),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .push_valid (push_valid),
        .push_word  (push_word),
        .push_ready (push_ready),
        .drop_count (drop_count)
    );

    async_fifo_core fifo_i (
        .wclk       (wclk),
        .wrst_n     (wrst_n),
        .push_valid (push_valid),
        .push_word  (push_word),
        .push_ready (push_ready),
        .rclk       (rclk),
        .rrst_n     (rrst_n),
        .pop_word   (pop_word),
        .pop_valid  (pop_valid),
        .pop_ready  (pop_ready)
    );

    read_egress egress_i (
        .rclk           (rclk),
        .rrst_n         (rrst_n),
        .pop_valid      (pop_valid),
        .pop_word       (pop_word),
        .pop_ready      (pop_ready),
        .out_valid      (out_valid),
        .out_data       (out_data),
        .out_gap        (out_gap),
        .out_parity_err (out_parity_err)
    );

endmodule

`default_nettype wire

/* rtl/read_egress.sv */
// Read-domain stage that drains the FIFO, strips the tag and flags sequence gaps and parity faults.
`timescale 1ns/1ps
`default_nettype none

module read_egress
    import xfer_pkg::*;
(
    input  logic       rclk,
    input  logic       rrst_n,
    input  logic       pop_valid,
    input  fifo_word_t pop_word,
    output logic       pop_ready,
    output logic       out_valid,
    output data_t      out_data,
    output logic       out_gap,
    output logic       out_parity_err
);

    logic  ready_q;
    logic  pop_fire;
    logic  valid_q;
    logic  gap_q;
    logic  perr_q;
    seq_t  exp_q;
    data_t data_q;

    // Output register is a strobe, so it is free every cycle after reset.
    assign pop_fire = pop_valid & ready_q;

    always_ff @(posedge rclk or negedge rrst_n) begin
        if (!rrst_n) begin
            ready_q <= 1'b0;
            valid_q <= 1'b0;
            gap_q   <= 1'b0;
            perr_q  <= 1'b0;
            exp_q   <= '0;
        end else begin
            ready_q <= 1'b1;
            valid_q <= pop_fire;
            if (pop_fire) begin
                gap_q  <= pop_word.seq != exp_q;
                perr_q <= ^pop_word;  // Odd count over the whole word.
                exp_q  <= pop_word.seq + 1'b1;  // Resync on the received tag.
            end else begin
                gap_q  <= 1'b0;
                perr_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge rclk) begin
        if (pop_fire) begin
            data_q <= pop_word.data;
        end
    end

    assign pop_ready      = ready_q;
    assign out_valid      = valid_q;
    assign out_data       = data_q;
    assign out_gap        = gap_q;
    assign out_parity_err = perr_q;

endmodule

`default_nettype wire

/* rtl/write_ingress.sv */
// Write-domain stage that tags each strobed byte and pushes it, counting words lost to full.
`timescale 1ns/1ps
`default_nettype none

`include "xfer_config.svh"

module write_ingress
    import xfer_pkg::*;
(
    input  logic                    wclk,
    input  logic                    wrst_n,
    input  logic                    in_valid,
    input  data_t                   in_data,
    output logic                    push_valid,
    output fifo_word_t              push_word,
    input  logic                    push_ready,
    output logic [`XFER_DROP_W-1:0] drop_count
);

    seq_t                    tag_q;
    logic                    valid_q;
    fifo_word_t              word_q;
    logic [`XFER_DROP_W-1:0] drop_q;

    always_ff @(posedge wclk or negedge wrst_n) begin
        if (!wrst_n) begin
            valid_q <= 1'b0;
            tag_q   <= '0;
            drop_q  <= '0;
        end else begin
            valid_q <= in_valid;
            if (in_valid) begin
                tag_q <= tag_q + 1'b1;  // Advances even if the word is later dropped.
            end
            if (valid_q && !push_ready && drop_q != '1) begin
                drop_q <= drop_q + 1'b1;
            end
        end
    end

    always_ff @(posedge wclk) begin
        if (in_valid) begin
            word_q.data   <= in_data;
            word_q.seq    <= tag_q;
            word_q.parity <= ^{tag_q, in_data};  // Even parity.
        end
    end

    assign push_valid = valid_q;
    assign push_word  = word_q;
    assign drop_count = drop_q;

endmodule

`default_nettype wire

/* rtl/async_fifo_core.sv */
// Gray-pointer dual-clock FIFO between the ingress and egress stages, valid/ready on each side.
`timescale 1ns/1ps
`default_nettype none

`include "xfer_config.svh"

module async_fifo_core
    import xfer_pkg::*;
(
    input  logic       wclk,
    input  logic       wrst_n,
    input  logic       push_valid,
    input  fifo_word_t push_word,
    output logic       push_ready,
    input  logic       rclk,
    input  logic       rrst_n,
    output fifo_word_t pop_word,
    output logic       pop_valid,
    input  logic       pop_ready
);

    localparam int DEPTH = `XFER_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);
    localparam int PW    = AW + 1;  // Extra wrap bit.
    localparam int WW    = $bits(fifo_word_t);
    // Pointer XOR pattern when the writer is one lap ahead.
    localparam logic [PW-1:0] FULL_XOR = {2'b11, {(PW-2){1'b0}}};

    logic          push_fire;
    logic          full;
    logic [PW-1:0] wbin;
    logic [PW-1:0] wbin_nx;
    logic [PW-1:0] wgray;
    logic [PW-1:0] rgray_wsync;

    logic          pop_fire;
    logic          empty;
    logic [PW-1:0] rbin;
    logic [PW-1:0] rbin_nx;
    logic [PW-1:0] rgray;
    logic [PW-1:0] wgray_rsync;

    logic [WW-1:0]    mem [DEPTH];
    logic [DEPTH-1:0] wr_en;
    logic [DEPTH-1:0] rd_sel;
    logic [WW-1:0]    rd_mux;

    // ------------------------------------------------------------------------
    // Write side
    // ------------------------------------------------------------------------
    assign full       = (wgray ^ rgray_wsync) == FULL_XOR;
    assign push_ready = ~full;
    assign push_fire  = push_valid & push_ready;
    assign wbin_nx    = wbin + 1'b1;

    always_ff @(posedge wclk or negedge wrst_n) begin
        if (!wrst_n) begin
            wbin  <= '0;
            wgray <= '0;
        end else if (push_fire) begin
            wbin  <= wbin_nx;
            wgray <= wbin_nx ^ (wbin_nx >> 1);
        end
    end

    assign wr_en = {DEPTH{push_fire}} & (DEPTH'(1) << wbin[AW-1:0]);  // One-hot row.

    for (genvar row = 0; row < DEPTH; row++) begin : gen_row
        always_ff @(posedge wclk) begin
            if (wr_en[row]) begin
                mem[row] <= push_word;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Read side
    // ------------------------------------------------------------------------
    assign empty     = rgray == wgray_rsync;
    assign pop_valid = ~empty;
    assign pop_fire  = pop_valid & pop_ready;
    assign rbin_nx   = rbin + 1'b1;

    always_ff @(posedge rclk or negedge rrst_n) begin
        if (!rrst_n) begin
            rbin  <= '0;
            rgray <= '0;
        end else if (pop_fire) begin
            rbin  <= rbin_nx;
            rgray <= rbin_nx ^ (rbin_nx >> 1);
        end
    end

    assign rd_sel = DEPTH'(1) << rbin[AW-1:0];

    always_comb begin
        rd_mux = '0;
        for (int j = 0; j < DEPTH; j++) begin
            rd_mux = rd_mux | ({WW{rd_sel[j]}} & mem[j]);  // AND-OR mux.
        end
    end

    assign pop_word = rd_mux;

    // ------------------------------------------------------------------------
    // Pointer crossings
    // ------------------------------------------------------------------------
    cdc_sync_bits #(.WIDTH(PW), .STAGES(`XFER_SYNC_STAGES)) wptr_sync_i (
        .clk    (rclk),
        .arst_n (rrst_n),
        .d      (wgray),
        .q      (wgray_rsync)
    );

    cdc_sync_bits #(.WIDTH(PW), .STAGES(`XFER_SYNC_STAGES)) rptr_sync_i (
        .clk    (wclk),
        .arst_n (wrst_n),
        .d      (rgray),
        .q      (rgray_wsync)
    );

endmodule

`default_nettype wire

/* rtl/cdc_sync_bits.sv */
// Flop chain synchronizer for gray pointers and reset release, one chain per bit.
`timescale 1ns/1ps
`default_nettype none

module cdc_sync_bits #(
    parameter int WIDTH  = 1,
    parameter int STAGES = 2
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [WIDTH-1:0] d,
    output logic [WIDTH-1:0] q
);

    logic [WIDTH-1:0] chain [STAGES];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < STAGES; i++) begin
                chain[i] <= '0;
            end
        end else begin
            chain[0] <= d;  // First stage may go metastable.
            for (int i = 1; i < STAGES; i++) begin
                chain[i] <= chain[i-1];
            end
        end
    end

    assign q = chain[STAGES-1];

endmodule

`default_nettype wire

/* rtl/xfer_pkg.sv */
// Shared data, tag and FIFO word types, imported by every stage of the transfer path.
`default_nettype none

`include "xfer_config.svh"

package xfer_pkg;

    typedef logic [`XFER_DATA_W-1:0] data_t;
    typedef logic [`XFER_SEQ_W-1:0]  seq_t;

    // Word as stored in the FIFO, parity on top.
    typedef struct packed {
        logic  parity;  // Even parity over seq and data.
        seq_t  seq;
        data_t data;
    } fifo_word_t;

endpackage

`default_nettype wire

/* rtl/xfer_config.svh */
// Build-time sizes for the byte transfer path, included by the package and the RTL.
`ifndef XFER_CONFIG_SVH
`define XFER_CONFIG_SVH

`define XFER_DATA_W      8   // Sample byte.
`define XFER_SEQ_W       4   // Sequence tag.
`define XFER_FIFO_DEPTH  8   // Words, power of two.
`define XFER_SYNC_STAGES 2   // Flops per synchronizer.
`define XFER_DROP_W      8   // Saturating drop counter.

`endif
